// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;

    // Major opcodes.
    localparam opcode_t op_lui     = 7'b0110111;
    localparam opcode_t op_auipc   = 7'b0010111;
    localparam opcode_t op_jal     = 7'b1101111;
    localparam opcode_t op_jalr    = 7'b1100111;
    localparam opcode_t op_load    = 7'b0000011;
    localparam opcode_t op_store   = 7'b0100011;
    localparam opcode_t op_branch  = 7'b1100011;
    localparam opcode_t op_int_imm = 7'b0010011;
    localparam opcode_t op_int     = 7'b0110011;

    // ALU funct3 codes.
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Branch funct3 codes.
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Access size, funct3 bits 1:0.
    localparam logic [1:0] acc_byte = 2'b00;
    localparam logic [1:0] acc_half = 2'b01;
    localparam logic [1:0] acc_word = 2'b10;

    localparam word_t reset_pc = 32'h0000_0000;

    typedef enum logic [1:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_write
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  wire logic [2:0] funct3,
    input  wire logic       alt,
    input  wire word_t      a,
    input  wire word_t      b,
    output word_t           y
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (funct3)
            f3_add:  y = alt ? a - b : a + b;
            f3_sll:  y = a << shamt;
            f3_slt:  y = {{(xlen-1){1'b0}}, lt_s};
            f3_sltu: y = {{(xlen-1){1'b0}}, lt_u};
            f3_xor:  y = a ^ b;
            f3_sr: begin
                if (alt) begin
                    y = word_t'($signed(a) >>> shamt); // Arithmetic shift.
                end else begin
                    y = a >> shamt;
                end
            end
            f3_or:   y = a | b;
            default: y = a & b;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    output word_t         rs1_data,
    output word_t         rs2_data,
    input  wire logic     we,
    input  wire reg_idx_t rd,
    input  wire word_t    rd_data
);

    word_t regs [1:31]; // x0 has no storage.

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  wire word_t instr,
    output opcode_t    opcode,
    output reg_idx_t   rd,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output logic [2:0] funct3,
    output logic       funct7_alt,
    output word_t      imm,
    output logic       rd_we
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign opcode     = instr[6:0];
    assign rd         = instr[11:7];
    assign funct3     = instr[14:12];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign funct7_alt = instr[30]; // SUB and SRA/SRAI.

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm   = '0;
        rd_we = 1'b0;
        case (opcode)
            op_lui, op_auipc: begin
                imm   = imm_u;
                rd_we = 1'b1;
            end
            op_jal: begin
                imm   = imm_j;
                rd_we = 1'b1;
            end
            op_jalr, op_load, op_int_imm: begin
                imm   = imm_i;
                rd_we = 1'b1;
            end
            op_int: begin
                rd_we = 1'b1;
            end
            op_store: imm = imm_s;
            op_branch: imm = imm_b;
            default: ; // Unknown opcode retires with no effect.
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec
    import rv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       en,
    input  wire opcode_t    opcode,
    input  wire logic [2:0] funct3,
    input  wire logic       funct7_alt,
    input  wire word_t      pc,
    input  wire word_t      rs1_data,
    input  wire word_t      rs2_data,
    input  wire word_t      imm,
    input  wire word_t      dmem_rdata,
    input  wire logic       dmem_ready,
    output word_t           result,
    output word_t           next_pc,
    output logic            redirect,
    output logic            done,
    output logic            dmem_req,
    output logic            dmem_we,
    output word_t           dmem_addr,
    output word_t           dmem_wdata,
    output logic [3:0]      dmem_be
);

    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_y;
    logic [2:0] alu_f3;
    logic       alu_alt;
    word_t      tgt_a;
    word_t      tgt_sum;
    logic       is_mem;
    logic       take;
    logic [1:0] acc;
    word_t      lane;
    word_t      load_val;
    word_t      val;

    rv_alu u_alu (
        .funct3 (alu_f3),
        .alt    (alu_alt),
        .a      (alu_a),
        .b      (alu_b),
        .y      (alu_y)
    );

    // Second adder for jump/branch targets and memory addresses.
    assign tgt_sum = tgt_a + imm;

    always_comb begin
        alu_a   = '0;
        alu_b   = '0;
        alu_f3  = f3_add;
        alu_alt = 1'b0;
        tgt_a   = rs1_data;
        case (opcode)
            op_lui: alu_a = imm;
            op_auipc: begin
                alu_a = imm;
                alu_b = pc;
            end
            op_jal: begin
                alu_a = 32'd4; // Link value.
                alu_b = pc;
                tgt_a = pc;
            end
            op_jalr: begin
                alu_a = 32'd4;
                alu_b = pc;
            end
            op_int_imm: begin
                alu_a   = rs1_data;
                alu_b   = imm;
                alu_f3  = funct3;
                alu_alt = funct7_alt && funct3 == f3_sr; // ADDI has no subtract.
            end
            op_int: begin
                alu_a   = rs1_data;
                alu_b   = rs2_data;
                alu_f3  = funct3;
                alu_alt = funct7_alt;
            end
            op_branch: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
                tgt_a = pc;
                case (funct3)
                    f3_beq, f3_bne:   alu_alt = 1'b1;
                    f3_blt, f3_bge:   alu_f3  = f3_slt;
                    f3_bltu, f3_bgeu: alu_f3  = f3_sltu;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        case (funct3)
            f3_beq:           take = alu_y == '0;
            f3_bne:           take = alu_y != '0;
            f3_blt, f3_bltu:  take = alu_y[0];
            f3_bge, f3_bgeu:  take = !alu_y[0];
            default:          take = 1'b0;
        endcase
    end

    assign redirect = opcode == op_jal || opcode == op_jalr || (opcode == op_branch && take);
    assign next_pc  = (opcode == op_jalr) ? {tgt_sum[xlen-1:1], 1'b0} : tgt_sum;

    assign is_mem   = opcode == op_load || opcode == op_store;
    assign acc      = funct3[1:0];
    assign dmem_req = en && is_mem && !done;
    assign dmem_we  = dmem_req && opcode == op_store;
    assign dmem_addr = tgt_sum;

    always_comb begin
        case (acc)
            acc_byte: begin
                dmem_be    = 4'b0001 << dmem_addr[1:0];
                dmem_wdata = {4{rs2_data[7:0]}};
            end
            acc_half: begin
                dmem_be    = dmem_addr[1] ? 4'b1100 : 4'b0011;
                dmem_wdata = {2{rs2_data[15:0]}};
            end
            default: begin
                dmem_be    = 4'b1111;
                dmem_wdata = rs2_data;
            end
        endcase
    end

    // Move the addressed lane down to bit 0, funct3[2] selects zero extension.
    assign lane = dmem_rdata >> {dmem_addr[1:0], 3'b000};

    always_comb begin
        case (acc)
            acc_byte: load_val = funct3[2] ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
            acc_half: load_val = funct3[2] ? {16'h0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
            acc_word: load_val = lane;
            default:  load_val = lane;
        endcase
    end

    assign val = (opcode == op_load) ? load_val : alu_y;

    always_ff @(posedge clk) begin
        if (en && !done && (!is_mem || dmem_ready)) begin
            result <= val; // Read data is only valid in the ready cycle.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (!en) begin
            done <= 1'b0;
        end else if (!is_mem || dmem_ready) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_control
    import rv_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire word_t imem_rdata,
    input  wire logic  imem_ready,
    input  wire logic  exec_done,
    input  wire word_t next_pc,
    input  wire logic  redirect,
    output logic       imem_req,
    output word_t      imem_addr,
    output word_t      instr,
    output word_t      pc,
    output logic       exec_en,
    output logic       wb_en
);

    ctrl_state_t state;
    logic        fetch_ack;

    assign fetch_ack = imem_req && imem_ready;
    assign imem_addr = pc;
    assign exec_en   = state == st_exec;
    assign wb_en     = state == st_write;

    always_ff @(posedge clk) begin
        if (fetch_ack) begin
            instr <= imem_rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_fetch;
            imem_req <= 1'b0;
            pc       <= reset_pc;
        end else begin
            case (state)
                st_fetch: begin
                    if (fetch_ack) begin
                        imem_req <= 1'b0;
                        state    <= st_decode;
                    end else begin
                        imem_req <= 1'b1; // Raised once after reset.
                    end
                end
                st_decode: state <= st_exec;
                st_exec: begin
                    if (exec_done) begin
                        pc    <= redirect ? next_pc : pc + 32'd4;
                        state <= st_write;
                    end
                end
                st_write: begin
                    imem_req <= 1'b1;
                    state    <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       arst_n,
    output logic            imem_req,
    output word_t           imem_addr,
    input  wire word_t      imem_rdata,
    input  wire logic       imem_ready,
    output logic            dmem_req,
    output logic            dmem_we,
    output word_t           dmem_addr,
    output word_t           dmem_wdata,
    output logic [3:0]      dmem_be,
    input  wire word_t      dmem_rdata,
    input  wire logic       dmem_ready
);

    word_t      instr;
    word_t      pc;
    word_t      next_pc;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      result;
    opcode_t    opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    logic       funct7_alt;
    logic       rd_we;
    logic       rf_we;
    logic       exec_en;
    logic       exec_done;
    logic       wb_en;
    logic       redirect;

    assign rf_we = wb_en && rd_we;

    rv_control u_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_rdata (imem_rdata),
        .imem_ready (imem_ready),
        .exec_done  (exec_done),
        .next_pc    (next_pc),
        .redirect   (redirect),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .instr      (instr),
        .pc         (pc),
        .exec_en    (exec_en),
        .wb_en      (wb_en)
    );

    rv_decode u_decode (
        .instr      (instr),
        .opcode     (opcode),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .funct3     (funct3),
        .funct7_alt (funct7_alt),
        .imm        (imm),
        .rd_we      (rd_we)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (rd),
        .rd_data  (result)
    );

    rv_exec u_exec (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (exec_en),
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7_alt (funct7_alt),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .dmem_rdata (dmem_rdata),
        .dmem_ready (dmem_ready),
        .result     (result),
        .next_pc    (next_pc),
        .redirect   (redirect),
        .done       (exec_done),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be)
    );

endmodule

`default_nettype wire

// ==== tests/rv_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties
    import rv_pkg::*;
(
    input wire logic        clk,
    input wire logic        arst_n,
    input wire logic        imem_req,
    input wire word_t       imem_addr,
    input wire logic        imem_ready,
    input wire logic        dmem_req,
    input wire logic        dmem_we,
    input wire word_t       dmem_addr,
    input wire word_t       dmem_wdata,
    input wire logic [3:0]  dmem_be,
    input wire logic        dmem_ready,
    input wire ctrl_state_t state
);

    imem_hold: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req && !imem_ready |=> imem_req && $stable(imem_addr))
        else $error("imem request dropped or changed before ready");

    dmem_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_req && !dmem_ready |=> dmem_req && $stable(dmem_addr) && $stable(dmem_we)
            && $stable(dmem_wdata) && $stable(dmem_be))
        else $error("dmem request dropped or changed before ready");

    // Data accesses belong to the execute state only.
    dmem_in_exec: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_req |-> state == st_exec)
        else $error("dmem request outside the execute state");

    reset_state: assert property (@(posedge clk) $rose(arst_n) |-> state == st_fetch)
        else $error("FSM not in fetch state after reset release");

endmodule

bind rv_core rv_core_properties u_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ready (imem_ready),
    .dmem_req   (dmem_req),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_be    (dmem_be),
    .dmem_ready (dmem_ready),
    .state      (u_control.state)
);

`default_nettype wire

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    logic        clk;
    logic        arst_n;
    logic        imem_req;
    word_t       imem_addr;
    word_t       imem_rdata;
    logic        imem_ready;
    logic        dmem_req;
    logic        dmem_we;
    word_t       dmem_addr;
    word_t       dmem_wdata;
    logic [3:0]  dmem_be;
    word_t       dmem_rdata;
    logic        dmem_ready;

    word_t       mem [0:1023]; // Shared instruction and data memory.
    word_t       ref_mem [0:1023];
    word_t       m_regs [0:31];
    word_t       m_pc;
    word_t       halt_pc;
    logic [31:0] lfsr;
    logic        exp_store;
    word_t       exp_addr;
    word_t       exp_data;
    logic [3:0]  exp_be;
    logic        halted;
    int          prog_ptr;
    int          out_off;
    int          imem_wait;
    int          dmem_wait;
    int          errors;
    int          n_fetch;
    int          n_store;
    int          cycles;

    rv_core dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_ready (imem_ready),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_rdata (dmem_rdata),
        .dmem_ready (dmem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // One LFSR step per bit taken.
    function automatic word_t draw_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_int};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                    input opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic emit(input word_t ins);
        mem[prog_ptr] = ins;
        ref_mem[prog_ptr] = ins;
        prog_ptr++;
    endtask

    // LUI plus ADDI, the upper part rounded for the signed low half.
    task automatic load_const(input reg_idx_t rd, input word_t v);
        word_t up;
        up = v + 32'h0000_0800;
        emit(enc_u(up[31:12], rd, op_lui));
        emit(enc_i(v[11:0], rd, 3'b000, rd, op_int_imm));
    endtask

    task automatic store_out(input reg_idx_t rs);
        emit(enc_s(out_off[11:0], rs, 5'd16, 3'b010)); // Result area at x16.
        out_off += 4;
    endtask

    task automatic build_program();
        word_t      v;
        logic [2:0] bf [0:5];
        reg_idx_t   bra [0:3];
        reg_idx_t   brb [0:3];
        int         w;
        bf  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        bra = '{5'd8, 5'd9, 5'd9, 5'd2};
        brb = '{5'd9, 5'd8, 5'd9, 5'd3};
        for (int i = 0; i < 1024; i++) begin
            v = word_t'(i) * 32'h9E37_79B1 + 32'h0F1E_2D3C;
            mem[i] = v;
            ref_mem[i] = v;
        end
        prog_ptr = 0;
        out_off = 0;
        load_const(5'd1, 32'h0000_0800);
        load_const(5'd16, 32'h0000_0A00);
        load_const(5'd2, draw_bits(32));
        load_const(5'd3, draw_bits(32));
        load_const(5'd8, 32'hFFFF_FFFF);
        load_const(5'd9, 32'h0000_0001);
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(7'h00, 5'd3, 5'd2, f[2:0], 5'd5));
            store_out(5'd5);
        end
        emit(enc_r(7'h20, 5'd3, 5'd2, 3'b000, 5'd5)); // SUB.
        store_out(5'd5);
        emit(enc_r(7'h20, 5'd3, 5'd2, 3'b101, 5'd5));
        store_out(5'd5);
        emit(enc_r(7'h20, 5'd2, 5'd3, 3'b101, 5'd5));
        store_out(5'd5);
        emit(enc_r(7'h00, 5'd9, 5'd8, 3'b010, 5'd5)); // Signed and unsigned disagree.
        store_out(5'd5);
        emit(enc_r(7'h00, 5'd9, 5'd8, 3'b011, 5'd5));
        store_out(5'd5);
        for (int f = 0; f < 8; f++) begin
            v = draw_bits(12);
            if (f != 1 && f != 5) begin
                emit(enc_i(v[11:0], 5'd2, f[2:0], 5'd5, op_int_imm));
                store_out(5'd5);
            end
        end
        v = draw_bits(5);
        emit(enc_i({7'h00, v[4:0]}, 5'd2, 3'b001, 5'd5, op_int_imm));
        store_out(5'd5);
        emit(enc_i({7'h00, v[4:0]}, 5'd2, 3'b101, 5'd5, op_int_imm));
        store_out(5'd5);
        emit(enc_i({7'h20, v[4:0]}, 5'd2, 3'b101, 5'd5, op_int_imm));
        store_out(5'd5);
        for (int k = 0; k < 4; k++) begin
            v = draw_bits(4);
            emit(enc_i({6'h00, v[3:0], 2'b00} + 12'(k), 5'd1, 3'b000, 5'd6, op_load));
            store_out(5'd6);
            emit(enc_i({6'h00, v[3:0], 2'b00} + 12'(k), 5'd1, 3'b100, 5'd6, op_load));
            store_out(5'd6);
        end
        for (int k = 0; k < 4; k += 2) begin
            v = draw_bits(4);
            emit(enc_i({6'h00, v[3:0], 2'b00} + 12'(k), 5'd1, 3'b001, 5'd6, op_load));
            store_out(5'd6);
            emit(enc_i({6'h00, v[3:0], 2'b00} + 12'(k), 5'd1, 3'b101, 5'd6, op_load));
            store_out(5'd6);
        end
        emit(enc_i(12'h01C, 5'd1, 3'b010, 5'd6, op_load));
        store_out(5'd6);
        w = out_off;
        out_off += 4;
        emit(enc_s(12'(w + 1), 5'd3, 5'd16, 3'b000)); // Byte lane 1.
        emit(enc_s(12'(w + 2), 5'd2, 5'd16, 3'b001)); // Upper half.
        emit(enc_i(12'(w), 5'd16, 3'b010, 5'd6, op_load));
        store_out(5'd6);
        for (int p = 0; p < 4; p++) begin
            for (int j = 0; j < 6; j++) begin
                emit(enc_b(13'd8, brb[p], bra[p], bf[j]));
                emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, op_int_imm));
            end
        end
        store_out(5'd7);
        emit(enc_j(21'd8, 5'd10));
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd11, op_int_imm));
        store_out(5'd10);
        store_out(5'd11);
        emit(enc_u(20'h0_0000, 5'd12, op_auipc));
        emit(enc_i(12'd17, 5'd12, 3'b000, 5'd13, op_jalr)); // Odd target.
        emit(enc_i(12'd1, 5'd11, 3'b000, 5'd11, op_int_imm));
        emit(enc_i(12'd2, 5'd11, 3'b000, 5'd11, op_int_imm));
        store_out(5'd13);
        store_out(5'd12);
        store_out(5'd11);
        v = draw_bits(20);
        emit(enc_u(v[19:0], 5'd14, op_lui));
        store_out(5'd14);
        v = draw_bits(20);
        emit(enc_u(v[19:0], 5'd15, op_auipc));
        store_out(5'd15);
        halt_pc = word_t'(prog_ptr) << 2;
        emit(enc_j(21'd0, 5'd0)); // Jump to self.
    endtask

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return word_t'($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Executes the instruction at m_pc on the model state.
    function automatic void isa_step();
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        word_t      addr;
        word_t      ld;
        word_t      val;
        word_t      nxt;
        logic [2:0] f3;
        logic       wr;
        ins = ref_mem[m_pc[11:2]];
        f3 = ins[14:12];
        a = m_regs[ins[19:15]];
        b = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt = m_pc + 32'd4;
        val = nxt; // Link value.
        wr = 1'b1;
        addr = a + imm_i;
        case (ins[6:0])
            op_lui: val = imm_u;
            op_auipc: val = m_pc + imm_u;
            op_jal: nxt = m_pc + imm_j;
            op_jalr: nxt = addr & ~32'd1;
            op_branch: begin
                wr = 1'b0;
                if (branch_taken(f3, a, b)) nxt = m_pc + imm_b;
            end
            op_int_imm: val = alu_model(f3, ins[30] && f3 == 3'b101, a, imm_i);
            op_int: val = alu_model(f3, ins[30], a, b);
            op_load: begin
                ld = ref_mem[addr[11:2]] >> {addr[1:0], 3'b000};
                case (f3)
                    3'b000: val = {{24{ld[7]}}, ld[7:0]};
                    3'b001: val = {{16{ld[15]}}, ld[15:0]};
                    3'b100: val = {24'h0, ld[7:0]};
                    3'b101: val = {16'h0, ld[15:0]};
                    default: val = ld;
                endcase
            end
            op_store: begin
                wr = 1'b0;
                addr = a + imm_s;
                case (f3[1:0])
                    2'b00: begin
                        exp_be = 4'b0001 << addr[1:0];
                        exp_data = {24'h0, b[7:0]} << {addr[1:0], 3'b000};
                    end
                    2'b01: begin
                        exp_be = addr[1] ? 4'b1100 : 4'b0011;
                        exp_data = {16'h0, b[15:0]} << {addr[1], 4'h0};
                    end
                    default: begin
                        exp_be = 4'b1111;
                        exp_data = b;
                    end
                endcase
                for (int i = 0; i < 4; i++) begin
                    if (exp_be[i]) ref_mem[addr[11:2]][8*i +: 8] = exp_data[8*i +: 8];
                end
                exp_addr = addr;
                exp_store = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = val;
        m_pc = nxt;
    endfunction

    // Memory model, ready after 0 to 3 idle cycles.
    always @(posedge clk) begin
        if (!arst_n) begin
            imem_ready <= 1'b0;
            dmem_ready <= 1'b0;
        end else begin
            if (imem_ready) begin
                imem_ready <= 1'b0;
            end else if (imem_req) begin
                if (imem_wait == 0) begin
                    imem_ready <= 1'b1;
                    imem_rdata <= mem[imem_addr[11:2]];
                    imem_wait = int'(draw_bits(2));
                end else begin
                    imem_wait--;
                end
            end
            if (dmem_ready) begin
                dmem_ready <= 1'b0;
            end else if (dmem_req) begin
                if (dmem_wait == 0) begin
                    dmem_ready <= 1'b1;
                    dmem_rdata <= mem[dmem_addr[11:2]];
                    for (int i = 0; i < 4; i++) begin
                        if (dmem_we && dmem_be[i]) begin
                            mem[dmem_addr[11:2]][8*i +: 8] = dmem_wdata[8*i +: 8];
                        end
                    end
                    dmem_wait = int'(draw_bits(2));
                end else begin
                    dmem_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        word_t mask;
        if (arst_n) begin
            if (imem_req && imem_ready) begin
                n_fetch++;
                if (exp_store) begin
                    $display("Store to %h never reached the data port", exp_addr);
                    errors++;
                    exp_store = 1'b0;
                end
                if (imem_addr !== m_pc) begin
                    $display("ERR imem_addr got %h expected %h", imem_addr, m_pc);
                    errors++;
                end
                if (m_pc == halt_pc) begin
                    halted = 1'b1;
                end else begin
                    isa_step();
                end
            end
            if (dmem_req && dmem_ready && dmem_we) begin
                n_store++;
                if (!exp_store) begin
                    $display("Unexpected data write to %h", dmem_addr);
                    errors++;
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        mask[8*i +: 8] = {8{exp_be[i]}};
                    end
                    if (dmem_addr !== exp_addr) begin
                        $display("ERR dmem_addr got %h expected %h", dmem_addr, exp_addr);
                        errors++;
                    end
                    if (dmem_be !== exp_be) begin
                        $display("ERR dmem_be got %h expected %h", dmem_be, exp_be);
                        errors++;
                    end
                    if ((dmem_wdata & mask) !== (exp_data & mask)) begin
                        $display("ERR dmem_wdata got %h expected %h", dmem_wdata & mask,
                                 exp_data & mask);
                        errors++;
                    end
                    exp_store = 1'b0;
                end
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        imem_rdata = '0;
        imem_ready = 1'b0;
        dmem_rdata = '0;
        dmem_ready = 1'b0;
        lfsr = 32'h5423;
        errors = 0;
        n_fetch = 0;
        n_store = 0;
        imem_wait = 0;
        dmem_wait = 0;
        halted = 1'b0;
        exp_store = 1'b0;
        m_pc = reset_pc;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        build_program();
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        cycles = 0;
        while (!halted && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: the core did not reach the halt loop in %0d cycles", cycles);
            errors++;
        end
        $display("Fetches %0d, stores %0d, errors %0d", n_fetch, n_store, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/rv_pkg.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_exec.sv
design/rv_control.sv
design/rv_core.sv
tests/rv_core_properties.sv
tests/tb_rv_core.sv
